/* logic/avr_pkg.sv */
// avr core shared definitions
// widths, bus structs, sequencer enums and opcode classes

package avr_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int PC_AW     = 11;
  localparam int GPR_COUNT = 32;

  typedef logic [7:0]       byte_t;
  typedef logic [15:0]      instr_t;
  typedef logic [PC_AW-1:0] pc_t;
  typedef logic [4:0]       reg_idx_t;
  typedef logic [5:0]       io_addr_t;

  // status register sits in the top I/O slot
  localparam io_addr_t IO_ADDR_SREG = 6'h3F;

  // opcode classes, upper bits of the instruction word
  localparam logic [3:0] OPC_RJMP = 4'b1100;
  localparam logic [4:0] OPC_BRBX = 5'b11110;
  localparam logic [4:0] OPC_IN   = 5'b10110;
  localparam logic [4:0] OPC_OUT  = 5'b10111;
  localparam logic [3:0] OPC_CPI  = 4'b0011;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic i;
    logic t;
    logic h;
    logic s;
    logic v;
    logic n;
    logic z;
    logic c;
  } sreg_t;

  // peripheral bus request
  typedef struct packed {
    logic     re;
    logic     we;
    io_addr_t a;
    byte_t    wdata;
  } io_req_t;

  // register file write
  typedef struct packed {
    logic     en;
    reg_idx_t dest;
    byte_t    data;
  } reg_wb_t;

  typedef struct packed {
    logic  en;
    sreg_t value;
  } flag_upd_t;

  ////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_NORMAL,
    SEQ_STALL,
    SEQ_WRITEBACK
  } seq_state_t;

  typedef enum logic [1:0] {
    PC_HOLD,
    PC_INC,
    PC_REL12,
    PC_REL7
  } pc_sel_t;

  typedef enum logic {
    IO_SEL_EXT,
    IO_SEL_SREG
  } io_sel_t;

endpackage : avr_pkg

/* logic/avr_gpr.sv */
// general purpose register file
// 32 x 8, two asynchronous read ports, one synchronous write port

`timescale 1ns/1ps

module avr_gpr (
  input  logic              clk,
  input  logic              rst,
  input  avr_pkg::reg_idx_t rd_idx,
  input  avr_pkg::reg_idx_t rr_idx,
  output avr_pkg::byte_t    rd_data,
  output avr_pkg::byte_t    rr_data,
  input  avr_pkg::reg_wb_t  wb
);
  import avr_pkg::*;

  byte_t [GPR_COUNT-1:0] regs;

  // write lands at the edge that ends the instruction
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (wb.en) begin
      regs[wb.dest] <= wb.data;
    end
  end

  // read ports
  assign rd_data = regs[rd_idx];
  assign rr_data = regs[rr_idx];

endmodule : avr_gpr

/* logic/avr_alu.sv */
// data path ALU
// decodes data operations, computes result, flags and register write

`timescale 1ns/1ps

module avr_alu (
  input  avr_pkg::instr_t    instr,
  input  logic               alu_en,
  input  avr_pkg::byte_t     rd_data,
  input  avr_pkg::byte_t     rr_data,
  input  avr_pkg::byte_t     in_data,
  input  avr_pkg::sreg_t     sreg,
  output avr_pkg::reg_idx_t  rd_idx,
  output avr_pkg::reg_idx_t  rr_idx,
  output avr_pkg::reg_wb_t   reg_wb,
  output avr_pkg::flag_upd_t flag_upd
);
  import avr_pkg::*;

  logic       imm_form;
  byte_t      k_imm;
  byte_t      opb;
  byte_t      res;
  logic [8:0] sum;
  logic       ovf;
  logic       keep_z;
  logic       svnz_en;
  logic       flag_en;
  logic       wr_en;
  sreg_t      nf;

  ////////////////////////////////////////
  // operand fields
  ////////////////////////////////////////

  // immediate forms only reach r16..r31
  assign imm_form = instr[14] | (instr[15:12] == OPC_CPI);
  assign rd_idx   = imm_form ? {1'b1, instr[7:4]} : instr[8:4];
  assign rr_idx   = {instr[9], instr[3:0]};
  assign k_imm    = {instr[11:8], instr[3:0]};
  assign opb      = imm_form ? k_imm : rr_data;

  ////////////////////////////////////////
  // result and flags
  ////////////////////////////////////////

  always_comb begin
    res     = rd_data;
    sum     = '0;
    ovf     = 1'b0;
    keep_z  = 1'b0;
    svnz_en = 1'b0;
    flag_en = 1'b0;
    wr_en   = 1'b0;
    nf      = sreg;
    if (alu_en) begin
      casez (instr)
        // ADD, ADC
        16'b000?_11??_????_????: begin
          sum     = {1'b0, rd_data} + {1'b0, opb} + {8'd0, instr[12] & sreg.c};
          res     = sum[7:0];
          nf.c    = sum[8];
          nf.h    = (rd_data[3] & opb[3]) | (opb[3] & ~res[3]) | (~res[3] & rd_data[3]);
          ovf     = (rd_data[7] & opb[7] & ~res[7]) | (~rd_data[7] & ~opb[7] & res[7]);
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        // SUB, SBC, CP, CPC and SUBI, SBCI, CPI
        16'b000?_10??_????_????,
        16'b000?_01??_????_????,
        16'b010?_????_????_????,
        16'b0011_????_????_????: begin
          sum     = {1'b0, rd_data} - {1'b0, opb} - {8'd0, ~instr[12] & sreg.c};
          res     = sum[7:0];
          nf.c    = sum[8];
          nf.h    = (~rd_data[3] & opb[3]) | (opb[3] & res[3]) | (res[3] & ~rd_data[3]);
          ovf     = (rd_data[7] & ~opb[7] & ~res[7]) | (~rd_data[7] & opb[7] & res[7]);
          // carry forms chain Z across bytes
          keep_z  = ~instr[12];
          svnz_en = 1'b1;
          // compares leave the destination alone
          wr_en   = imm_form ? instr[14] : instr[11];
        end
        // AND, ANDI
        16'b0010_00??_????_????,
        16'b0111_????_????_????: begin
          res     = rd_data & opb;
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        // OR, ORI
        16'b0010_10??_????_????,
        16'b0110_????_????_????: begin
          res     = rd_data | opb;
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b0010_01??_????_????: begin
          res     = rd_data ^ rr_data;
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b0010_11??_????_????: begin
          res   = rr_data;
          wr_en = 1'b1;
        end
        16'b1110_????_????_????: begin
          res   = k_imm;
          wr_en = 1'b1;
        end
        // BSET/BCLR, bit 7 picks clear
        16'b1001_0100_????_1000: begin
          nf[instr[6:4]] = ~instr[7];
          flag_en        = 1'b1;
        end
        16'b1001_010?_????_0000: begin
          res     = ~rd_data;
          nf.c    = 1'b1;
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b1001_010?_????_0001: begin
          sum     = 9'd0 - {1'b0, rd_data};
          res     = sum[7:0];
          nf.c    = sum[8];
          nf.h    = res[3] | rd_data[3];
          ovf     = (res == 8'h80);
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b1001_010?_????_0011: begin
          res     = rd_data + 8'd1;
          ovf     = (res == 8'h80);
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b1001_010?_????_1010: begin
          res     = rd_data - 8'd1;
          ovf     = (res == 8'h7f);
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        // LSR, ROR
        16'b1001_010?_????_011?: begin
          res     = {instr[0] & sreg.c, rd_data[7:1]};
          nf.c    = rd_data[0];
          ovf     = res[7] ^ rd_data[0];
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b1001_010?_????_0101: begin
          res     = {rd_data[7], rd_data[7:1]};
          nf.c    = rd_data[0];
          ovf     = res[7] ^ rd_data[0];
          svnz_en = 1'b1;
          wr_en   = 1'b1;
        end
        16'b1001_010?_????_0010: begin
          res   = {rd_data[3:0], rd_data[7:4]};
          wr_en = 1'b1;
        end
        // IN, only reached in writeback
        {OPC_IN, 11'b???_????_????}: begin
          res   = in_data;
          wr_en = 1'b1;
        end
        default: begin
          wr_en = 1'b0;
        end
      endcase
    end
    if (svnz_en) begin
      nf.n = res[7];
      nf.v = ovf;
      nf.s = res[7] ^ ovf;
      nf.z = (res == 8'h00) & (~keep_z | sreg.z);
    end
  end

  assign reg_wb.en      = wr_en;
  assign reg_wb.dest    = rd_idx;
  assign reg_wb.data    = res;
  assign flag_upd.en    = svnz_en | flag_en;
  assign flag_upd.value = nf;

endmodule : avr_alu

/* logic/avr_io_regs.sv */
// I/O register block
// status register and the registered source select for IN

`timescale 1ns/1ps

module avr_io_regs (
  input  logic               clk,
  input  logic               rst,
  input  avr_pkg::flag_upd_t flag_upd,
  input  avr_pkg::io_req_t   io,
  input  avr_pkg::byte_t     io_rdata,
  output avr_pkg::sreg_t     sreg,
  output avr_pkg::byte_t     in_data
);
  import avr_pkg::*;

  io_sel_t io_sel;
  logic    sreg_hit;

  assign sreg_hit = (io.a == IO_ADDR_SREG);

  ////////////////////////////////////////
  // status register
  ////////////////////////////////////////

  // OUT wins over an ALU flag update in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sreg <= '0;
    end else if (io.we && sreg_hit) begin
      sreg <= io.wdata;
    end else if (flag_upd.en) begin
      sreg <= flag_upd.value;
    end
  end

  ////////////////////////////////////////
  // IN source
  ////////////////////////////////////////

  // sampled during the read strobe, used one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      io_sel <= IO_SEL_EXT;
    end else begin
      io_sel <= sreg_hit ? IO_SEL_SREG : IO_SEL_EXT;
    end
  end

  always_comb begin
    case (io_sel)
      IO_SEL_SREG: in_data = sreg;
      default:     in_data = io_rdata;
    endcase
  end

endmodule : avr_io_regs

/* logic/avr_sequencer.sv */
// instruction sequencer
// program counter, fetch control, jumps, branches and I/O strobes

`timescale 1ns/1ps

module avr_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  avr_pkg::instr_t  instr,
  input  avr_pkg::sreg_t   sreg,
  input  avr_pkg::byte_t   rd_data,
  output logic             pmem_ce,
  output avr_pkg::pc_t     pmem_a,
  output logic             alu_en,
  output avr_pkg::io_req_t io
);
  import avr_pkg::*;

  pc_t         pc;
  pc_t         pc_inc;
  pc_sel_t     pc_sel;
  seq_state_t  state;
  seq_state_t  state_nxt;
  logic        br_taken;
  logic [15:0] rel12_ext;
  logic [15:0] rel7_ext;

  // pc holds the address of the word being executed
  assign pc_inc = pc + pc_t'(1);
  assign pmem_a = pc_inc;

  // a fetch is issued whenever the pc moves on by one
  assign pmem_ce = (pc_sel == PC_INC);

  // sign extended jump offsets
  assign rel12_ext = {{4{instr[11]}}, instr[11:0]};
  assign rel7_ext  = {{9{instr[9]}}, instr[9:3]};

  // bit 10 selects BRBC
  assign br_taken = sreg[instr[2:0]] ^ instr[10];

  ////////////////////////////////////////
  // program counter
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '1;
    end else begin
      case (pc_sel)
        PC_INC:   pc <= pc_inc;
        PC_REL12: pc <= pc + pc_t'(rel12_ext);
        PC_REL7:  pc <= pc + pc_t'(rel7_ext);
        default:  pc <= pc;
      endcase
    end
  end

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  // the first cycle out of reset behaves as a stall and fetches word 0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= SEQ_STALL;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    pc_sel    = PC_HOLD;
    alu_en    = 1'b0;
    io        = '0;
    io.a      = {instr[10:9], instr[3:0]};
    io.wdata  = rd_data;
    case (state)
      SEQ_NORMAL: begin
        casez (instr)
          {OPC_RJMP, 12'b????_????_????}: begin
            pc_sel    = PC_REL12;
            state_nxt = SEQ_STALL;
          end
          {OPC_BRBX, 11'b???_????_????}: begin
            if (br_taken) begin
              pc_sel    = PC_REL7;
              state_nxt = SEQ_STALL;
            end else begin
              pc_sel = PC_INC;
            end
          end
          {OPC_IN, 11'b???_????_????}: begin
            // word stays on pmem_d until writeback
            io.re     = 1'b1;
            state_nxt = SEQ_WRITEBACK;
          end
          {OPC_OUT, 11'b???_????_????}: begin
            io.we  = 1'b1;
            pc_sel = PC_INC;
          end
          default: begin
            alu_en = 1'b1;
            pc_sel = PC_INC;
          end
        endcase
      end
      SEQ_STALL: begin
        pc_sel    = PC_INC;
        state_nxt = SEQ_NORMAL;
      end
      SEQ_WRITEBACK: begin
        // IN result lands in the register file here
        alu_en    = 1'b1;
        pc_sel    = PC_INC;
        state_nxt = SEQ_NORMAL;
      end
      default: begin
        state_nxt = SEQ_NORMAL;
      end
    endcase
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  io_strobe_excl: assert property (
    @(posedge clk) disable iff (rst) !(io.re && io.we)
  ) else $error("io read and write strobes overlap");

  wb_single_cycle: assert property (
    @(posedge clk) disable iff (rst)
      (state == SEQ_WRITEBACK) |=> (state != SEQ_WRITEBACK)
  ) else $error("writeback state held for two cycles");

endmodule : avr_sequencer

/* logic/avr_core.sv */
// avr core top level
// connects sequencer, register file, data path ALU and I/O registers

`timescale 1ns/1ps

module avr_core (
  input  logic             clk,
  input  logic             rst,
  // program memory
  output logic             pmem_ce,
  output avr_pkg::pc_t     pmem_a,
  input  avr_pkg::instr_t  pmem_d,
  // peripheral bus
  output avr_pkg::io_req_t io,
  input  avr_pkg::byte_t   io_rdata
);
  import avr_pkg::*;

  logic      alu_en;
  reg_idx_t  rd_idx;
  reg_idx_t  rr_idx;
  byte_t     rd_data;
  byte_t     rr_data;
  byte_t     in_data;
  sreg_t     sreg;
  reg_wb_t   reg_wb;
  flag_upd_t flag_upd;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  avr_sequencer seq_i (
    .clk     (clk),
    .rst     (rst),
    .instr   (pmem_d),
    .sreg    (sreg),
    .rd_data (rd_data),
    .pmem_ce (pmem_ce),
    .pmem_a  (pmem_a),
    .alu_en  (alu_en),
    .io      (io)
  );

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////

  avr_gpr gpr_i (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rr_idx  (rr_idx),
    .rd_data (rd_data),
    .rr_data (rr_data),
    .wb      (reg_wb)
  );

  avr_alu alu_i (
    .instr    (pmem_d),
    .alu_en   (alu_en),
    .rd_data  (rd_data),
    .rr_data  (rr_data),
    .in_data  (in_data),
    .sreg     (sreg),
    .rd_idx   (rd_idx),
    .rr_idx   (rr_idx),
    .reg_wb   (reg_wb),
    .flag_upd (flag_upd)
  );

  // status register and IN source select
  avr_io_regs io_regs_i (
    .clk      (clk),
    .rst      (rst),
    .flag_upd (flag_upd),
    .io       (io),
    .io_rdata (io_rdata),
    .sreg     (sreg),
    .in_data  (in_data)
  );

endmodule : avr_core

/* verification/avr_ref_model.svh */
// avr core reference model
// expected data results and status flags, and an instruction encoder

`ifndef AVR_REF_MODEL_SVH
`define AVR_REF_MODEL_SVH

typedef enum int {
  OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP, OP_CPC, OP_AND, OP_OR,
  OP_EOR, OP_MOV, OP_LDI, OP_SUBI, OP_SBCI, OP_CPI, OP_ANDI, OP_ORI,
  OP_COM, OP_NEG, OP_INC, OP_DEC, OP_LSR, OP_ROR, OP_ASR, OP_SWAP
} op_t;

////////////////////////////////////////
// encoder
////////////////////////////////////////

function automatic instr_t enc_rr(input logic [5:0] opc, input reg_idx_t d, input reg_idx_t r);
  return {opc, r[4], d, r[3:0]};
endfunction

// immediate forms address r16..r31
function automatic instr_t enc_imm(input logic [3:0] opc, input reg_idx_t d, input byte_t k);
  return {opc, k[7:4], d[3:0], k[3:0]};
endfunction

function automatic instr_t enc_one(input logic [3:0] opc, input reg_idx_t d);
  return {7'b1001010, d, opc};
endfunction

function automatic instr_t enc_in(input reg_idx_t d, input io_addr_t a);
  return {5'b10110, a[5:4], d, a[3:0]};
endfunction

function automatic instr_t enc_out(input io_addr_t a, input reg_idx_t r);
  return {5'b10111, a[5:4], r, a[3:0]};
endfunction

function automatic instr_t enc_rjmp(input logic [11:0] k);
  return {4'b1100, k};
endfunction

// clr high gives BRBC
function automatic instr_t enc_brbx(input logic clr, input logic [2:0] s, input logic [6:0] k);
  return {5'b11110, clr, k, s};
endfunction

function automatic instr_t enc_op(input op_t op, input reg_idx_t d, input reg_idx_t r,
                                  input byte_t k);
  case (op)
    OP_ADD:  return enc_rr(6'b000011, d, r);
    OP_ADC:  return enc_rr(6'b000111, d, r);
    OP_SUB:  return enc_rr(6'b000110, d, r);
    OP_SBC:  return enc_rr(6'b000010, d, r);
    OP_CP:   return enc_rr(6'b000101, d, r);
    OP_CPC:  return enc_rr(6'b000001, d, r);
    OP_AND:  return enc_rr(6'b001000, d, r);
    OP_OR:   return enc_rr(6'b001010, d, r);
    OP_EOR:  return enc_rr(6'b001001, d, r);
    OP_MOV:  return enc_rr(6'b001011, d, r);
    OP_LDI:  return enc_imm(4'b1110, d, k);
    OP_SUBI: return enc_imm(4'b0101, d, k);
    OP_SBCI: return enc_imm(4'b0100, d, k);
    OP_CPI:  return enc_imm(4'b0011, d, k);
    OP_ANDI: return enc_imm(4'b0111, d, k);
    OP_ORI:  return enc_imm(4'b0110, d, k);
    OP_COM:  return enc_one(4'b0000, d);
    OP_NEG:  return enc_one(4'b0001, d);
    OP_INC:  return enc_one(4'b0011, d);
    OP_DEC:  return enc_one(4'b1010, d);
    OP_LSR:  return enc_one(4'b0110, d);
    OP_ROR:  return enc_one(4'b0111, d);
    OP_ASR:  return enc_one(4'b0101, d);
    default: return enc_one(4'b0010, d);
  endcase
endfunction

////////////////////////////////////////
// expected result and flags
////////////////////////////////////////

// wr is the value the destination holds afterwards
function automatic void ref_alu(input op_t op, input byte_t a, input byte_t b,
                                input sreg_t si, output byte_t wr, output sreg_t so);
  int    cin;
  int    sum;
  int    sdiff;
  int    sa;
  int    sb;
  byte_t r;
  logic  v;
  logic  upd;
  logic  chain;
  so    = si;
  sa    = $signed(a);
  sb    = $signed(b);
  r     = a;
  v     = 1'b0;
  upd   = 1'b1;
  chain = 1'b0;
  cin   = 0;
  case (op)
    OP_ADD, OP_ADC: begin
      if (op == OP_ADC) begin
        cin = si.c;
      end
      sum   = int'(a) + int'(b) + cin;
      r     = sum[7:0];
      so.c  = (sum > 255);
      so.h  = (int'(a[3:0]) + int'(b[3:0]) + cin) > 15;
      sdiff = sa + sb + cin;
      v     = (sdiff > 127) || (sdiff < -128);
    end
    OP_SUB, OP_SBC, OP_CP, OP_CPC, OP_SUBI, OP_SBCI, OP_CPI: begin
      // carry forms borrow in and chain Z
      if (op == OP_SBC || op == OP_CPC || op == OP_SBCI) begin
        cin   = si.c;
        chain = 1'b1;
      end
      sum   = int'(a) - int'(b) - cin;
      r     = sum[7:0];
      so.c  = (sum < 0);
      so.h  = (int'(a[3:0]) - int'(b[3:0]) - cin) < 0;
      sdiff = sa - sb - cin;
      v     = (sdiff > 127) || (sdiff < -128);
    end
    OP_AND, OP_ANDI: r = a & b;
    OP_OR, OP_ORI:   r = a | b;
    OP_EOR:          r = a ^ b;
    OP_MOV, OP_LDI: begin
      r   = b;
      upd = 1'b0;
    end
    OP_COM: begin
      r    = ~a;
      so.c = 1'b1;
    end
    OP_NEG: begin
      r    = 8'd0 - a;
      so.c = (a != 8'd0);
      so.h = (a[3:0] != 4'd0);
      v    = (a == 8'h80);
    end
    OP_INC: begin
      r = a + 8'd1;
      v = (a == 8'h7f);
    end
    OP_DEC: begin
      r = a - 8'd1;
      v = (a == 8'h80);
    end
    OP_LSR, OP_ROR, OP_ASR: begin
      r = a >> 1;
      if (op == OP_ROR) begin
        r[7] = si.c;
      end
      if (op == OP_ASR) begin
        r[7] = a[7];
      end
      so.c = a[0];
      // V is N xor C after a shift
      v    = r[7] ^ a[0];
    end
    default: begin
      r   = {a[3:0], a[7:4]};
      upd = 1'b0;
    end
  endcase
  if (upd) begin
    so.n = r[7];
    so.v = v;
    so.s = r[7] ^ v;
    so.z = (r == 8'd0) && (!chain || si.z);
  end
  wr = (op == OP_CP || op == OP_CPC || op == OP_CPI) ? a : r;
endfunction

`endif

/* verification/avr_core_tb.sv */
// avr core testbench
// runs small programs from a ROM model and checks every OUT write

`timescale 1ns/1ps

module avr_core_tb;
  import avr_pkg::*;

  `include "avr_ref_model.svh"

  localparam int       TIMEOUT   = 2000;
  localparam int       N_PAIRS   = 20;
  localparam io_addr_t DONE_ADDR = 6'h2A;
  localparam io_addr_t EXT_ADDR  = 6'h05;

  logic        clk;
  logic        rst;
  logic        pmem_ce;
  pc_t         pmem_a;
  instr_t      pmem_d;
  io_req_t     io;
  byte_t       io_rdata;

  instr_t      rom [0:(1 << PC_AW)-1];
  instr_t      prog [$];
  logic [13:0] exp_q [$];
  logic [13:0] got_q [$];
  pc_t         fetch_a;
  logic        done_seen;
  byte_t       ext_byte;
  byte_t       a_val [N_PAIRS];
  byte_t       b_val [N_PAIRS];
  byte_t       s_val [N_PAIRS];
  int          seed;
  int          test_err;
  int          n_tests;
  int          n_failed;

  avr_core dut_i (
    .clk      (clk),
    .rst      (rst),
    .pmem_ce  (pmem_ce),
    .pmem_a   (pmem_a),
    .pmem_d   (pmem_d),
    .io       (io),
    .io_rdata (io_rdata)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // memory, peripheral and monitor
  ////////////////////////////////////////

  // synchronous program memory
  always @(posedge clk) begin
    if (pmem_ce) begin
      fetch_a = pmem_a;
      #1 pmem_d = rom[fetch_a];
    end
  end

  // read data only valid in the cycle after io.re
  always @(posedge clk) begin
    if (io.re) begin
      #1 io_rdata = ext_byte;
    end else begin
      #1 io_rdata = ~ext_byte;
    end
  end

  always @(posedge clk) begin
    if (!rst && io.we) begin
      if (io.a == DONE_ADDR) begin
        done_seen = 1'b1;
      end else begin
        got_q.push_back({io.a, io.wdata});
      end
    end
  end

  ////////////////////////////////////////
  // program helpers
  ////////////////////////////////////////

  task automatic new_test();
    prog.delete();
    exp_q.delete();
    test_err = 0;
  endtask

  task automatic emit(input instr_t w);
    prog.push_back(w);
  endtask

  task automatic expect_write(input io_addr_t a, input byte_t d);
    exp_q.push_back({a, d});
  endtask

  // end marker, then a jump onto itself
  task automatic emit_end();
    emit(enc_out(DONE_ADDR, 5'd0));
    emit(enc_rjmp(12'hfff));
  endtask

  task automatic start_program();
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < (1 << PC_AW); i++) begin
      // unused words are LDIs tagged with their address
      rom[i] = {4'b1110, 1'b0, pc_t'(i)};
    end
    foreach (prog[i]) begin
      rom[i] = prog[i];
    end
    got_q.delete();
    done_seen = 1'b0;
    repeat (3) begin
      @(posedge clk);
      if (io.re || io.we) begin
        $display("io strobe high during reset");
        test_err++;
      end
    end
    #1 rst = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int cycles;
    cycles = 0;
    while (!done_seen && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done_seen) begin
      $display("%s: program did not reach its end marker in time", name);
      test_err++;
    end
    if (got_q.size() != exp_q.size()) begin
      $display("%s: saw %0d OUT writes where %0d were due", name, got_q.size(), exp_q.size());
      test_err++;
    end else begin
      foreach (exp_q[i]) begin
        if (got_q[i] !== exp_q[i]) begin
          $display("ERROR %s write %0d: expected %h:%h actual %h:%h", name, i,
                   exp_q[i][13:8], exp_q[i][7:0], got_q[i][13:8], got_q[i][7:0]);
          test_err++;
        end
      end
    end
    n_tests++;
    if (test_err == 0) begin
      $display("%s: pass", name);
    end else begin
      n_failed++;
      $display("%s: FAIL with %0d errors", name, test_err);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    int   cycles;
    logic seen;
    pc_t  first_a;
    new_test();
    emit_end();
    start_program();
    seen    = 1'b0;
    first_a = '1;
    cycles  = 0;
    while (!seen && cycles < 10) begin
      @(posedge clk);
      cycles++;
      if (io.re || io.we) begin
        $display("io strobe high right after reset");
        test_err++;
      end
      if (pmem_ce) begin
        seen    = 1'b1;
        first_a = pmem_a;
      end
    end
    if (!seen) begin
      $display("no program fetch after reset");
      test_err++;
    end else if (first_a != '0) begin
      $display("ERROR reset first fetch: expected %h actual %h", pc_t'(0), first_a);
      test_err++;
    end
    finish_test("reset");
  endtask

  // result to address 0, flags read back by IN to address 1
  task automatic test_alu(input op_t op);
    byte_t res;
    sreg_t flags;
    new_test();
    for (int p = 0; p < N_PAIRS; p++) begin
      emit(enc_op(OP_LDI, 5'd20, 5'd0, a_val[p]));
      emit(enc_op(OP_LDI, 5'd21, 5'd0, b_val[p]));
      emit(enc_op(OP_LDI, 5'd18, 5'd0, s_val[p]));
      emit(enc_out(IO_ADDR_SREG, 5'd18));
      emit(enc_op(op, 5'd20, 5'd21, b_val[p]));
      emit(enc_out(6'h00, 5'd20));
      emit(enc_in(5'd19, IO_ADDR_SREG));
      emit(enc_out(6'h01, 5'd19));
      ref_alu(op, a_val[p], b_val[p], s_val[p], res, flags);
      expect_write(IO_ADDR_SREG, s_val[p]);
      expect_write(6'h00, res);
      expect_write(6'h01, flags);
    end
    emit_end();
    start_program();
    finish_test(op.name());
  endtask

  task automatic test_branch();
    new_test();
    emit(enc_op(OP_LDI, 5'd16, 5'd0, 8'h01));
    emit(enc_op(OP_LDI, 5'd17, 5'd0, 8'h02));
    emit(enc_op(OP_LDI, 5'd18, 5'd0, 8'h03));
    emit(enc_op(OP_LDI, 5'd19, 5'd0, 8'h04));
    emit(enc_rjmp(12'd1));
    emit(enc_out(6'h00, 5'd16));
    emit(enc_out(6'h00, 5'd17));
    // Z set, BRBS taken then BRBC falls through
    emit(enc_op(OP_CPI, 5'd16, 5'd0, 8'h01));
    emit(enc_brbx(1'b0, 3'd1, 7'd1));
    emit(enc_out(6'h00, 5'd16));
    emit(enc_brbx(1'b1, 3'd1, 7'd1));
    emit(enc_out(6'h00, 5'd18));
    // Z clear, the other way round
    emit(enc_op(OP_CPI, 5'd16, 5'd0, 8'h02));
    emit(enc_brbx(1'b0, 3'd1, 7'd1));
    emit(enc_out(6'h00, 5'd19));
    emit(enc_brbx(1'b1, 3'd1, 7'd1));
    emit(enc_out(6'h00, 5'd16));
    emit_end();
    expect_write(6'h00, 8'h02);
    expect_write(6'h00, 8'h03);
    expect_write(6'h00, 8'h04);
    start_program();
    finish_test("branch");
  endtask

  task automatic test_io();
    byte_t rnd;
    rnd      = $random(seed);
    ext_byte = $random(seed);
    new_test();
    emit(enc_op(OP_LDI, 5'd22, 5'd0, rnd));
    emit(enc_out(IO_ADDR_SREG, 5'd22));
    emit(enc_in(5'd23, IO_ADDR_SREG));
    emit(enc_out(6'h00, 5'd23));
    emit(enc_in(5'd24, EXT_ADDR));
    emit(enc_out(6'h00, 5'd24));
    emit_end();
    expect_write(IO_ADDR_SREG, rnd);
    expect_write(6'h00, rnd);
    expect_write(6'h00, ext_byte);
    start_program();
    finish_test("io");
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    pmem_d    = '0;
    io_rdata  = '0;
    ext_byte  = '0;
    done_seen = 1'b0;
    seed      = 88;
    n_tests   = 0;
    n_failed  = 0;
    for (int p = 0; p < N_PAIRS; p++) begin
      a_val[p] = $random(seed);
      b_val[p] = $random(seed);
      s_val[p] = $random(seed);
    end
    // equal operands so subtracts reach zero once
    b_val[0] = a_val[0];
    test_reset();
    for (int k = 0; k <= int'(OP_SWAP); k++) begin
      test_alu(op_t'(k));
    end
    test_branch();
    test_io();
    $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed, n_failed);
    if (n_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : avr_core_tb

/* files.f */
+incdir+verification
logic/avr_pkg.sv
logic/avr_gpr.sv
logic/avr_alu.sv
logic/avr_io_regs.sv
logic/avr_sequencer.sv
logic/avr_core.sv
verification/avr_core_tb.sv

/* Bender.yml */
package:
  name: avr_core

sources:
  - logic/avr_pkg.sv
  - logic/avr_gpr.sv
  - logic/avr_alu.sv
  - logic/avr_io_regs.sv
  - logic/avr_sequencer.sv
  - logic/avr_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/avr_core_tb.sv
